// File: src/image_scaler_pkg.sv
package image_scaler_pkg;

    // Wide enough for a 320x240 enlarged frame
    localparam int ADDR_W = 19;

    typedef logic [7:0] pixel_t;

    typedef logic [ADDR_W-1:0] frame_addr_t;

    // Transform selected by the mode input
    typedef enum logic [1:0] {
        MODE_COPY,
        MODE_REPLICATE,
        MODE_DECIMATE,
        MODE_AVERAGE
    } scale_mode_t;

    // RAM write port
    typedef struct packed {
        frame_addr_t addr;
        pixel_t      data;
        logic        en;
    } ram_write_t;

    // Everything one engine drives towards the top
    typedef struct packed {
        frame_addr_t rom_addr;
        ram_write_t  wr;
        logic        done;
    } engine_out_t;

endpackage

// File: src/frame_copy.sv
module frame_copy #(
    parameter int SRC_WIDTH  = 160,
    parameter int SRC_HEIGHT = 120
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  image_scaler_pkg::pixel_t      rom_data,
    output image_scaler_pkg::engine_out_t eng
);
    import image_scaler_pkg::*;

    localparam frame_addr_t NUM_PIXELS = frame_addr_t'(SRC_WIDTH * SRC_HEIGHT);

    frame_addr_t cnt;
    frame_addr_t rd_addr;
    frame_addr_t wr_addr;
    pixel_t      wr_data;
    logic        rd_valid;
    logic        wr_valid;
    logic        done_q;
    logic        issue;

    assign issue = run && (cnt != NUM_PIXELS);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt      <= '0;
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
            done_q   <= 1'b0;
        end else if (!run) begin
            cnt      <= '0;
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            if (issue) begin
                cnt <= cnt + 1'b1;
            end
            rd_valid <= issue;
            wr_valid <= rd_valid;
            // Rises once the last word has left the read stage
            done_q   <= (cnt == NUM_PIXELS) && !rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= cnt;
        wr_addr <= rd_addr;
        wr_data <= rom_data;
    end

    always_comb begin
        eng.rom_addr = cnt;
        eng.wr.addr  = wr_addr;
        eng.wr.data  = wr_data;
        eng.wr.en    = run && wr_valid;
        eng.done     = run && done_q;
    end

endmodule

// File: src/pixel_replicate.sv
module pixel_replicate #(
    parameter int SRC_WIDTH  = 160,
    parameter int SRC_HEIGHT = 120,
    parameter int SCALE      = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  image_scaler_pkg::pixel_t      rom_data,
    output image_scaler_pkg::engine_out_t eng
);
    import image_scaler_pkg::*;

    localparam int ROW_W     = $clog2(SRC_HEIGHT + 1);
    localparam int COL_W     = $clog2(SRC_WIDTH + 1);
    localparam int SUB_W     = $clog2(SCALE + 1);
    localparam int OUT_WIDTH = SRC_WIDTH * SCALE;

    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [SUB_W-1:0] di;
    logic [SUB_W-1:0] dj;
    logic             fin;
    logic             issue;
    logic             rd_valid;
    logic             wr_valid;
    logic             done_q;
    frame_addr_t      src_addr;
    frame_addr_t      dst_addr;
    frame_addr_t      rd_addr;
    frame_addr_t      wr_addr;
    pixel_t           wr_data;

    assign issue    = run && !fin;
    assign src_addr = frame_addr_t'(row) * frame_addr_t'(SRC_WIDTH) + frame_addr_t'(col);
    assign dst_addr = (frame_addr_t'(row) * frame_addr_t'(SCALE) + frame_addr_t'(di))
                      * frame_addr_t'(OUT_WIDTH)
                      + frame_addr_t'(col) * frame_addr_t'(SCALE) + frame_addr_t'(dj);

    // Walk order is row, sub-row, column, sub-column, which gives raster output
    always_ff @(posedge clk or negedge reset) begin
        if (!reset || !run) begin
            {row, col, di, dj}            <= '0;
            {fin, rd_valid, wr_valid}     <= '0;
            done_q                        <= 1'b0;
        end else begin
            if (issue) begin
                if (dj == SUB_W'(SCALE - 1)) begin
                    dj <= '0;
                    if (col == COL_W'(SRC_WIDTH - 1)) begin
                        col <= '0;
                        if (di == SUB_W'(SCALE - 1)) begin
                            di <= '0;
                            if (row == ROW_W'(SRC_HEIGHT - 1)) begin
                                fin <= 1'b1;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            di <= di + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    dj <= dj + 1'b1;
                end
            end
            rd_valid <= issue;
            wr_valid <= rd_valid;
            done_q   <= fin && !rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= dst_addr;
        wr_addr <= rd_addr;
        wr_data <= rom_data;
    end

    always_comb begin
        eng.rom_addr = src_addr;
        eng.wr.addr  = wr_addr;
        eng.wr.data  = wr_data;
        eng.wr.en    = run && wr_valid;
        eng.done     = run && done_q;
    end

endmodule

// File: src/pixel_decimate.sv
module pixel_decimate #(
    parameter int SRC_WIDTH  = 160,
    parameter int SRC_HEIGHT = 120,
    parameter int SCALE      = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  image_scaler_pkg::pixel_t      rom_data,
    output image_scaler_pkg::engine_out_t eng
);
    import image_scaler_pkg::*;

    localparam int ROW_W = $clog2(SRC_HEIGHT + 1);
    localparam int COL_W = $clog2(SRC_WIDTH + 1);

    logic [COL_W-1:0] x;
    logic [ROW_W-1:0] y;
    logic             fin;
    logic             issue;
    logic             rd_valid;
    logic             wr_valid;
    logic             done_q;
    frame_addr_t      out_cnt;
    pixel_t           wr_data;

    assign issue = run && !fin;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset || !run) begin
            x        <= '0;
            y        <= '0;
            fin      <= 1'b0;
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
            done_q   <= 1'b0;
            out_cnt  <= '0;
        end else begin
            if (issue) begin
                if (x == COL_W'(SRC_WIDTH - SCALE)) begin
                    x <= '0;
                    if (y == ROW_W'(SRC_HEIGHT - SCALE)) begin
                        fin <= 1'b1;
                    end else begin
                        y <= y + ROW_W'(SCALE);
                    end
                end else begin
                    x <= x + COL_W'(SCALE);
                end
            end
            rd_valid <= issue;
            wr_valid <= rd_valid;
            done_q   <= fin && !rd_valid;
            // Output pixels land in raster order, one address per write
            if (wr_valid) begin
                out_cnt <= out_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= rom_data;
    end

    always_comb begin
        eng.rom_addr = frame_addr_t'(y) * frame_addr_t'(SRC_WIDTH) + frame_addr_t'(x);
        eng.wr.addr  = out_cnt;
        eng.wr.data  = wr_data;
        eng.wr.en    = run && wr_valid;
        eng.done     = run && done_q;
    end

endmodule

// File: src/block_average.sv
module block_average #(
    parameter int SRC_WIDTH  = 160,
    parameter int SRC_HEIGHT = 120,
    parameter int SCALE      = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  image_scaler_pkg::pixel_t      rom_data,
    output image_scaler_pkg::engine_out_t eng
);
    import image_scaler_pkg::*;

    localparam int BLK_COLS = SRC_WIDTH / SCALE;
    localparam int BLK_ROWS = SRC_HEIGHT / SCALE;
    localparam int AREA     = SCALE * SCALE;
    localparam int BX_W     = $clog2(BLK_COLS + 1);
    localparam int BY_W     = $clog2(BLK_ROWS + 1);
    localparam int SUB_W    = $clog2(SCALE + 1);
    localparam int SUM_W    = $bits(pixel_t) + $clog2(AREA);

    typedef enum logic [1:0] {
        ST_READ,
        ST_ACCUM,
        ST_WRITE
    } blk_state_t;

    blk_state_t       state;
    logic [BX_W-1:0]  bx;
    logic [BY_W-1:0]  by;
    logic [SUB_W-1:0] sx;
    logic [SUB_W-1:0] sy;
    logic [SUM_W-1:0] sum;
    logic             done_q;
    logic             first_read;

    // Nothing has come back from the ROM yet on the first read of a block
    assign first_read = (sx == '0) && (sy == '0);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset || !run) begin
            state  <= ST_READ;
            {bx, by, sx, sy} <= '0;
            sum    <= '0;
            done_q <= 1'b0;
        end else if (!done_q) begin
            case (state)
                ST_READ: begin
                    if (!first_read) begin
                        sum <= sum + SUM_W'(rom_data);
                    end
                    if (sx == SUB_W'(SCALE - 1)) begin
                        sx <= '0;
                        if (sy == SUB_W'(SCALE - 1)) begin
                            sy    <= '0;
                            state <= ST_ACCUM;
                        end else begin
                            sy <= sy + 1'b1;
                        end
                    end else begin
                        sx <= sx + 1'b1;
                    end
                end
                ST_ACCUM: begin
                    sum   <= sum + SUM_W'(rom_data);
                    state <= ST_WRITE;
                end
                default: begin
                    sum   <= '0;
                    state <= ST_READ;
                    if (bx == BX_W'(BLK_COLS - 1)) begin
                        bx <= '0;
                        if (by == BY_W'(BLK_ROWS - 1)) begin
                            done_q <= 1'b1;
                        end else begin
                            by <= by + 1'b1;
                        end
                    end else begin
                        bx <= bx + 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        eng.rom_addr = (frame_addr_t'(by) * frame_addr_t'(SCALE) + frame_addr_t'(sy))
                       * frame_addr_t'(SRC_WIDTH)
                       + frame_addr_t'(bx) * frame_addr_t'(SCALE) + frame_addr_t'(sx);
        eng.wr.addr  = frame_addr_t'(by) * frame_addr_t'(BLK_COLS) + frame_addr_t'(bx);
        eng.wr.data  = pixel_t'(sum / SUM_W'(AREA));
        eng.wr.en    = run && (state == ST_WRITE);
        eng.done     = run && done_q;
    end

endmodule

// File: src/image_scaler.sv
module image_scaler #(
    parameter int SRC_WIDTH  = 160,
    parameter int SRC_HEIGHT = 120,
    parameter int SCALE      = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  image_scaler_pkg::scale_mode_t mode,
    output image_scaler_pkg::frame_addr_t rom_addr,
    input  image_scaler_pkg::pixel_t      rom_data,
    output image_scaler_pkg::ram_write_t  ram_wr,
    output logic                          done
);
    import image_scaler_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COPY,
        ST_REPLICATE,
        ST_DECIMATE,
        ST_AVERAGE
    } state_t;

    state_t      state;
    scale_mode_t mode_q;
    logic        run_copy;
    logic        run_replicate;
    logic        run_decimate;
    logic        run_average;
    engine_out_t copy_out;
    engine_out_t replicate_out;
    engine_out_t decimate_out;
    engine_out_t average_out;
    engine_out_t active_out;

    // Any change of mode passes through idle, so the old engine sees run low
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= ST_IDLE;
            mode_q <= MODE_COPY;
        end else if (state == ST_IDLE) begin
            mode_q <= mode;
            case (mode)
                MODE_COPY:      state <= ST_COPY;
                MODE_REPLICATE: state <= ST_REPLICATE;
                MODE_DECIMATE:  state <= ST_DECIMATE;
                default:        state <= ST_AVERAGE;
            endcase
        end else if (mode != mode_q) begin
            state <= ST_IDLE;
        end
    end

    assign run_copy      = (state == ST_COPY);
    assign run_replicate = (state == ST_REPLICATE);
    assign run_decimate  = (state == ST_DECIMATE);
    assign run_average   = (state == ST_AVERAGE);

    frame_copy #(.SRC_WIDTH(SRC_WIDTH), .SRC_HEIGHT(SRC_HEIGHT)) copy_inst (
        .clk(clk), .reset(reset), .run(run_copy), .rom_data(rom_data), .eng(copy_out)
    );

    pixel_replicate #(.SRC_WIDTH(SRC_WIDTH), .SRC_HEIGHT(SRC_HEIGHT), .SCALE(SCALE)) rep_inst (
        .clk(clk), .reset(reset), .run(run_replicate), .rom_data(rom_data), .eng(replicate_out)
    );

    pixel_decimate #(.SRC_WIDTH(SRC_WIDTH), .SRC_HEIGHT(SRC_HEIGHT), .SCALE(SCALE)) dec_inst (
        .clk(clk), .reset(reset), .run(run_decimate), .rom_data(rom_data), .eng(decimate_out)
    );

    block_average #(.SRC_WIDTH(SRC_WIDTH), .SRC_HEIGHT(SRC_HEIGHT), .SCALE(SCALE)) avg_inst (
        .clk(clk), .reset(reset), .run(run_average), .rom_data(rom_data), .eng(average_out)
    );

    // Plain mux, no register, so ROM latency stays as the engines expect
    always_comb begin
        case (state)
            ST_COPY:      active_out = copy_out;
            ST_REPLICATE: active_out = replicate_out;
            ST_DECIMATE:  active_out = decimate_out;
            ST_AVERAGE:   active_out = average_out;
            default:      active_out = '0;
        endcase
    end

    assign rom_addr = active_out.rom_addr;
    assign ram_wr   = active_out.wr;
    assign done     = active_out.done;

endmodule

// File: tb/image_scaler_assertions.sv
module image_scaler_assertions (
    input logic                          clk,
    input logic                          reset,
    input image_scaler_pkg::scale_mode_t mode,
    input image_scaler_pkg::frame_addr_t rom_addr,
    input image_scaler_pkg::ram_write_t  ram_wr,
    input logic                          done
);
    timeunit 1ns;
    timeprecision 1ps;

    import image_scaler_pkg::*;

    int unsigned failures = 0;

    write_not_with_done: assert property (
        @(posedge clk) disable iff (!reset) !(ram_wr.en && done)
    ) else begin
        failures = failures + 1;
        $error("RAM write enable and done are high in the same cycle");
    end

    // First cycle out of reset is still idle
    quiet_after_reset: assert property (
        @(posedge clk) $rose(reset) |-> (rom_addr == {ADDR_W{1'b0}} && !ram_wr.en && !done)
    ) else begin
        failures = failures + 1;
        $error("outputs active before the mode was latched");
    end

    done_holds: assert property (
        @(posedge clk) disable iff (!reset) (done && $stable(mode)) |=> done
    ) else begin
        failures = failures + 1;
        $error("done dropped while mode was stable");
    end

endmodule

bind image_scaler image_scaler_assertions image_scaler_assertions_inst (
    .clk(clk), .reset(reset), .mode(mode), .rom_addr(rom_addr), .ram_wr(ram_wr), .done(done)
);

// File: tb/image_scaler_tb.sv
module image_scaler_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import image_scaler_pkg::*;

    localparam int SRC_WIDTH        = 160;
    localparam int SRC_HEIGHT       = 120;
    localparam int SCALE            = 2;
    localparam int NUM_PIXELS       = SRC_WIDTH * SRC_HEIGHT;
    localparam int OUT_PIXELS       = NUM_PIXELS * SCALE * SCALE;
    localparam int BLK_COLS         = SRC_WIDTH / SCALE;
    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 10;
    localparam int HOLD_CYCLES      = 8;
    localparam int RUN_OVERHEAD     = 16;
    localparam int MAX_SWITCH_DELAY = 4000;
    localparam int SEED             = 32'ha8;

    logic        clk;
    logic        reset;
    scale_mode_t mode;
    frame_addr_t rom_addr;
    pixel_t      rom_data = '0;
    ram_write_t  ram_wr;
    logic        done;

    integer      seed;
    pixel_t      rom_mem [NUM_PIXELS];
    frame_addr_t rom_q = '0;
    pixel_t      captured [OUT_PIXELS];
    bit          written [OUT_PIXELS];
    frame_addr_t wr_count;

    image_scaler #(
        .SRC_WIDTH(SRC_WIDTH),
        .SRC_HEIGHT(SRC_HEIGHT),
        .SCALE(SCALE)
    ) image_scaler_inst (
        .clk(clk), .reset(reset), .mode(mode), .rom_addr(rom_addr),
        .rom_data(rom_data), .ram_wr(ram_wr), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Synchronous ROM that answers one cycle after the address
    always @(negedge clk) begin
        rom_q    <= rom_addr;
        rom_data <= (int'(rom_q) < NUM_PIXELS) ? rom_mem[rom_q] : '0;
    end

    // Write port as the RAM sees it on the next rising edge
    always @(negedge clk) begin
        if (ram_wr.en) begin
            if (int'(ram_wr.addr) >= OUT_PIXELS) begin
                fail_run($sformatf("RAM write to address %0d is outside the frame", ram_wr.addr));
            end else if (written[ram_wr.addr]) begin
                fail_run($sformatf("RAM address %0d was written twice", ram_wr.addr));
            end else begin
                captured[ram_wr.addr] = ram_wr.data;
                written[ram_wr.addr]  = 1'b1;
            end
            wr_count = wr_count + 1'b1;
        end
    end

    always @(negedge clk) begin
        if (image_scaler_inst.image_scaler_assertions_inst.failures != 0) begin
            fail_run("an assertion on the DUT outputs failed");
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act) begin
            fail_run($sformatf("** Error %s: expected %02h, actual %02h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input frame_addr_t exp, input frame_addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("** Error %s write count: expected %0d, actual %0d",
                               name, exp, act));
        end
    endtask

    function automatic int expected_writes(input scale_mode_t m);
        case (m)
            MODE_COPY:      return NUM_PIXELS;
            MODE_REPLICATE: return OUT_PIXELS;
            default:        return NUM_PIXELS / (SCALE * SCALE);
        endcase
    endfunction

    // Cycle budget of one run including start and hold
    function automatic int mode_cycles(input scale_mode_t m);
        case (m)
            MODE_COPY:      return NUM_PIXELS + 2 + RUN_OVERHEAD;
            MODE_REPLICATE: return OUT_PIXELS + 2 + RUN_OVERHEAD;
            MODE_DECIMATE:  return NUM_PIXELS / (SCALE * SCALE) + 2 + RUN_OVERHEAD;
            default:        return (NUM_PIXELS / (SCALE * SCALE)) * (SCALE * SCALE + 2)
                                   + RUN_OVERHEAD;
        endcase
    endfunction

    function automatic pixel_t expected_pixel(input scale_mode_t m, input int addr);
        int x;
        int y;
        int sum;
        case (m)
            MODE_COPY: return rom_mem[addr];
            MODE_REPLICATE: begin
                x = addr % (SRC_WIDTH * SCALE);
                y = addr / (SRC_WIDTH * SCALE);
                return rom_mem[(y / SCALE) * SRC_WIDTH + x / SCALE];
            end
            MODE_DECIMATE: begin
                x = addr % BLK_COLS;
                y = addr / BLK_COLS;
                return rom_mem[y * SCALE * SRC_WIDTH + x * SCALE];
            end
            default: begin
                sum = 0;
                for (int dy = 0; dy < SCALE; dy++) begin
                    for (int dx = 0; dx < SCALE; dx++) begin
                        sum += int'(rom_mem[((addr / BLK_COLS) * SCALE + dy) * SRC_WIDTH
                                            + (addr % BLK_COLS) * SCALE + dx]);
                    end
                end
                return pixel_t'(sum / (SCALE * SCALE));
            end
        endcase
    endfunction

    task automatic clear_capture();
        for (int a = 0; a < OUT_PIXELS; a++) begin
            written[a]  = 1'b0;
            captured[a] = '0;
        end
        wr_count = '0;
    endtask

    // Same mode again needs a one-cycle detour so the FSM passes through idle
    task automatic start_run(input scale_mode_t m);
        @(negedge clk);
        mode = (mode == m) ? scale_mode_t'((int'(m) + 1) % 4) : m;
        @(negedge clk);
        mode = m;
        clear_capture();
    endtask

    task automatic run_and_check(input scale_mode_t m, input string name);
        int total;
        start_run(m);
        if (done) begin
            fail_run($sformatf("%s: done is high before the run has started", name));
        end
        do @(negedge clk); while (!done);
        total = expected_writes(m);
        check_count(name, frame_addr_t'(total), wr_count);
        for (int a = 0; a < total; a++) begin
            if (!written[a]) begin
                fail_run($sformatf("%s: output address %0d was never written", name, a));
            end
            check_pixel($sformatf("%s addr %0d", name, a), expected_pixel(m, a), captured[a]);
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (!done) begin
                fail_run($sformatf("%s: done dropped while the mode was held", name));
            end else if (ram_wr.en) begin
                fail_run($sformatf("%s: RAM write while done was high", name));
            end
        end
        check_count(name, frame_addr_t'(total), wr_count);
    endtask

    initial begin : watchdog
        longint limit;
        limit = 2 * (RESET_CYCLES + MAX_SWITCH_DELAY + RUN_OVERHEAD + mode_cycles(MODE_REPLICATE)
                     + 2 * (mode_cycles(MODE_COPY) + mode_cycles(MODE_REPLICATE)
                            + mode_cycles(MODE_DECIMATE) + mode_cycles(MODE_AVERAGE)));
        #(limit * CLK_PERIOD);
        fail_run($sformatf("Timeout: the tests did not finish within %0d cycles", limit));
    end

    initial begin : stimulus
        scale_mode_t order [4];
        scale_mode_t first_mode;
        scale_mode_t next_mode;
        scale_mode_t tmp;
        int          pick;
        int          delay;
        seed  = SEED;
        reset = 1'b0;
        mode  = MODE_COPY;
        for (int i = 0; i < NUM_PIXELS; i++) begin
            rom_mem[i] = pixel_t'($random(seed));
        end
        clear_capture();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b1;

        run_and_check(MODE_COPY, "copy");
        run_and_check(MODE_REPLICATE, "replicate");
        run_and_check(MODE_DECIMATE, "decimate");
        run_and_check(MODE_AVERAGE, "average");

        // Switch to another mode before the first run can finish
        first_mode = scale_mode_t'($unsigned($random(seed)) % 4);
        pick       = int'($unsigned($random(seed)) % 3);
        next_mode  = scale_mode_t'((int'(first_mode) + 1 + pick) % 4);
        delay      = 1 + int'($unsigned($random(seed)) % MAX_SWITCH_DELAY);
        start_run(first_mode);
        repeat (delay) @(negedge clk);
        if (done) begin
            fail_run("mode switch: the first run finished before the switch");
        end
        run_and_check(next_mode, $sformatf("switch to %s", next_mode.name()));

        order = '{MODE_COPY, MODE_REPLICATE, MODE_DECIMATE, MODE_AVERAGE};
        for (int i = 3; i > 0; i--) begin
            pick        = int'($unsigned($random(seed)) % (i + 1));
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        for (int i = 0; i < 4; i++) begin
            run_and_check(order[i], $sformatf("sequence %0d %s", i, order[i].name()));
        end

        if (image_scaler_inst.image_scaler_assertions_inst.failures != 0) begin
            fail_run("an assertion on the DUT outputs failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: vlog.f
src/image_scaler_pkg.sv
src/frame_copy.sv
src/pixel_replicate.sv
src/pixel_decimate.sv
src/block_average.sv
src/image_scaler.sv
tb/image_scaler_assertions.sv
tb/image_scaler_tb.sv

// File: Makefile
TOP := image_scaler_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
